// ==== quplsPkg.sv ====
// Decode front end shared types
`default_nettype none

package quplsPkg;

	// ======================================================================
	// Instruction and register types
	// ======================================================================

	// A raw instruction word, opcode in bits 6:0
	// Register fields sit at 12:7, 18:13, 24:19 and 30:25
	typedef logic [31:0] instruction_t;

	// Architectural register number, one prefix bit above a six-bit field
	typedef logic [6:0] aregno_t;

	// Register extension prefix, one bit per register field
	// Bit 0 extends Rt (and Rc of a store), bit 1 Ra, bit 2 Rb, bit 3 Rc
	typedef logic [3:0] regx_t;

	// A full register value
	typedef logic [63:0] value_t;

	// ======================================================================
	// Register file constants
	// ======================================================================

	// Depth of the architectural register file
	localparam int NUM_REGS = 128;

	// Return with deallocate picks its Rc from a block of four at this base
	localparam aregno_t RTD_BASE = 7'd56;

	// ======================================================================
	// Opcodes
	// ======================================================================

	// Only the opcodes that this front end treats differently are named
	typedef enum logic [6:0]
	{
		OP_NOP = 7'h00,
		OP_ADD = 7'h04,
		OP_RTD = 7'h22,
		OP_LDO = 7'h46,
		// Stores of byte, wyde, tetra, octa and indexed form
		OP_STB = 7'h50,
		OP_STW = 7'h51,
		OP_STT = 7'h52,
		OP_STO = 7'h53,
		OP_STX = 7'h54
	} opcode_e;

	// Stores carry their data register in the Rt field, so Rt is not a target
	function automatic logic isStoreOp(opcode_e op);
		return op inside {OP_STB, OP_STW, OP_STT, OP_STO, OP_STX};
	endfunction

	// ======================================================================
	// Control encodings
	// ======================================================================

	// Owner of the single register file port in a given cycle
	typedef enum logic
	{
		PORT_WB,
		PORT_FETCH
	} portUser_e;

	// Operand fetcher sequencing
	typedef enum logic [1:0]
	{
		// Waiting for a decoded instruction
		FS_IDLE,
		// Requesting the port for the next source, or finishing if none left
		FS_REQ,
		// Read data for the granted source is on rdData
		FS_READ
	} fetchState_e;

endpackage

`default_nettype wire

// ==== decodeRc.sv ====
// Rc register number decode
`timescale 1ns/1ns
`default_nettype none

module decodeRc
(
	input quplsPkg::instruction_t instr,
	input quplsPkg::regx_t regx,
	output quplsPkg::aregno_t Rc
);

	import quplsPkg::*;

	// Opcode field viewed through the enum
	opcode_e op;

	// The Rc field moves around depending on the instruction format
	always_comb
	begin
		op = opcode_e'(instr[6:0]);
		if (op == OP_RTD)
		begin
			// Return picks one of four registers starting at the base
			Rc = RTD_BASE + {5'd0, instr[8:7]};
		end
		else if (isStoreOp(op))
		begin
			// Store data lives in the Rt slot and takes the Rt prefix bit
			Rc = {regx[0], instr[12:7]};
		end
		else
		begin
			// General format, top field with its own prefix bit
			Rc = {regx[3], instr[30:25]};
		end
	end

endmodule

`default_nettype wire

// ==== instrDecoder.sv ====
// Instruction register and field decoder
`timescale 1ns/1ns
`default_nettype none

module instrDecoder
(
	input wire logic clk,
	input wire logic rst,
	input wire logic instrValid,
	input quplsPkg::instruction_t instr,
	input quplsPkg::regx_t regx,
	output logic decValid,
	output quplsPkg::opcode_e decOp,
	output quplsPkg::aregno_t decRa,
	output quplsPkg::aregno_t decRb,
	output quplsPkg::aregno_t decRc,
	output quplsPkg::aregno_t decRt
);

	import quplsPkg::*;

	// Combinational decode of the incoming word
	opcode_e opNext;
	aregno_t rcNext;
	aregno_t rtNext;

	// ======================================================================
	// Field decode
	// ======================================================================

	// Rc has its own decoder since its position depends on the format
	decodeRc u_decodeRc
	(
		.instr(instr),
		.regx(regx),
		.Rc(rcNext)
	);

	always_comb
	begin
		opNext = opcode_e'(instr[6:0]);
		// A store has no target register, so Rt is forced to r0
		if (isStoreOp(opNext))
			rtNext = '0;
		else
			rtNext = {regx[0], instr[12:7]};
	end

	// ======================================================================
	// Output registers
	// ======================================================================

	// The strobe is a single cycle behind instrValid
	always_ff @(posedge clk)
	begin
		if (rst)
			decValid <= 1'b0;
		else
			decValid <= instrValid;
	end

	// Decoded fields hold until the next instruction arrives
	always_ff @(posedge clk)
	begin
		if (instrValid)
		begin
			decOp <= opNext;
			decRa <= {regx[1], instr[18:13]};
			decRb <= {regx[2], instr[24:19]};
			decRc <= rcNext;
			decRt <= rtNext;
		end
	end

	// Anything outside the known opcode set would be decoded as general format
	// and its Rc would be meaningless
	assert property (@(posedge clk) disable iff (rst)
		decValid |-> decOp inside {OP_NOP, OP_ADD, OP_LDO, OP_RTD,
			OP_STB, OP_STW, OP_STT, OP_STO, OP_STX})
		else $error("decoder presented an undefined opcode");

endmodule

`default_nettype wire

// ==== operandFetch.sv ====
// Operand fetch sequencer
`timescale 1ns/1ns
`default_nettype none

module operandFetch
(
	input wire logic clk,
	input wire logic rst,
	input wire logic decValid,
	input quplsPkg::aregno_t decRa,
	input quplsPkg::aregno_t decRb,
	input quplsPkg::aregno_t decRc,
	input quplsPkg::aregno_t decRt,
	output logic fetchReq,
	input wire logic fetchGnt,
	output quplsPkg::aregno_t fetchAddr,
	input quplsPkg::value_t rdData,
	output logic busy,
	output logic opValid,
	output quplsPkg::value_t opA,
	output quplsPkg::value_t opB,
	output quplsPkg::value_t opC,
	output quplsPkg::aregno_t opRt,
	output quplsPkg::aregno_t opRc
);

	import quplsPkg::*;

	fetchState_e state;
	// Sources still to be read, bit 0 Ra, bit 1 Rb, bit 2 Rc
	logic [2:0] pending;
	// One-hot pick of the lowest pending source
	logic [2:0] sel;
	// Source register numbers held for the whole fetch
	aregno_t ra;
	aregno_t rb;

	// Ra first, then Rb, then Rc
	always_comb
	begin
		sel = 3'b000;
		if (pending[0])
			sel = 3'b001;
		else if (pending[1])
			sel = 3'b010;
		else if (pending[2])
			sel = 3'b100;
	end

	always_comb
	begin
		case (sel)
		3'b001: fetchAddr = ra;
		3'b010: fetchAddr = rb;
		3'b100: fetchAddr = opRc;
		default: fetchAddr = '0;
		endcase
	end

	// The request stays up through any writeback stall since pending only
	// changes in FS_READ
	assign fetchReq = (state == FS_REQ) && (pending != 3'b000);
	// Nothing left to read means the operands are complete this cycle
	assign opValid = (state == FS_REQ) && (pending == 3'b000);
	// Busy covers everything up to and including the opValid cycle
	assign busy = (state != FS_IDLE);

	// ======================================================================
	// Sequencer
	// ======================================================================

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= FS_IDLE;
			pending <= 3'b000;
		end
		else
		begin
			case (state)
			FS_IDLE:
				if (decValid)
				begin
					// r0 reads as zero so it never needs the port
					pending <= {decRc != '0, decRb != '0, decRa != '0};
					state <= FS_REQ;
				end
			FS_REQ:
				if (opValid)
					state <= FS_IDLE;
				else if (fetchGnt)
					state <= FS_READ;
			FS_READ:
				begin
					pending <= pending & ~sel;
					state <= FS_REQ;
				end
			default:
				state <= FS_IDLE;
			endcase
		end
	end

	// Operand registers, cleared on a new instruction so r0 sources are zero
	always_ff @(posedge clk)
	begin
		if (state == FS_IDLE && decValid)
		begin
			ra <= decRa;
			rb <= decRb;
			opRc <= decRc;
			opRt <= decRt;
			opA <= '0;
			opB <= '0;
			opC <= '0;
		end
		else if (state == FS_READ)
		begin
			// Read data is for the source granted in the previous cycle
			if (sel[0])
				opA <= rdData;
			if (sel[1])
				opB <= rdData;
			if (sel[2])
				opC <= rdData;
		end
	end

	// The decoder has no stall, so its source must wait for opValid
	assert property (@(posedge clk) disable iff (rst) decValid |-> !busy)
		else $error("new instruction arrived during an operand fetch");

endmodule

`default_nettype wire

// ==== regWriter.sv ====
// Writeback holding buffer
`timescale 1ns/1ns
`default_nettype none

module regWriter
(
	input wire logic clk,
	input wire logic rst,
	input wire logic wbValid,
	input quplsPkg::aregno_t wbReg,
	input quplsPkg::value_t wbData,
	output logic wbFull,
	output logic wbReq,
	input wire logic wbGnt,
	output quplsPkg::aregno_t wrAddr,
	output quplsPkg::value_t wrData
);

	// A held write asks for the port until it is granted
	assign wbReq = wbFull;

	// ======================================================================
	// Buffer occupancy
	// ======================================================================

	// The grant and a new write never coincide since a full buffer refuses
	// writes and an empty one is never granted
	always_ff @(posedge clk)
	begin
		if (rst)
			wbFull <= 1'b0;
		else if (wbGnt)
			wbFull <= 1'b0;
		else if (wbValid && !wbFull && wbReg != '0)
			// Writes to r0 are dropped here and never reach the file
			wbFull <= 1'b1;
	end

	// Address and data of the held write
	always_ff @(posedge clk)
	begin
		if (wbValid && !wbFull)
		begin
			wrAddr <= wbReg;
			wrData <= wbData;
		end
	end

	// The source has to watch wbFull before it sends another write
	assert property (@(posedge clk) disable iff (rst) wbValid |-> !wbFull)
		else $error("writeback offered while the buffer is full");

endmodule

`default_nettype wire

// ==== regArbiter.sv ====
// Register file port arbiter
`timescale 1ns/1ns
`default_nettype none

module regArbiter
(
	input wire logic wbReq,
	input wire logic fetchReq,
	output logic wbGnt,
	output logic fetchGnt,
	input quplsPkg::aregno_t wrAddr,
	input quplsPkg::value_t wrData,
	input quplsPkg::aregno_t fetchAddr,
	output quplsPkg::aregno_t portAddr,
	output logic portWe,
	output quplsPkg::value_t portData
);

	import quplsPkg::*;

	// Requester driving the port this cycle
	portUser_e user;

	// ======================================================================
	// Fixed priority grant
	// ======================================================================

	// Writeback goes first so the one-entry buffer drains quickly and the
	// writeback source is held off as little as possible
	always_comb
	begin
		wbGnt = wbReq;
		fetchGnt = fetchReq && !wbReq;
		if (wbReq)
			user = PORT_WB;
		else
			user = PORT_FETCH;
	end

	// ======================================================================
	// Port mux
	// ======================================================================

	// With no request the fetch address is on the port, and the resulting
	// read is simply ignored
	always_comb
	begin
		portWe = (user == PORT_WB);
		portAddr = (user == PORT_WB) ? wrAddr : fetchAddr;
		// Only the writer has data, the strobe decides if it lands
		portData = wrData;
	end

endmodule

`default_nettype wire

// ==== regFile.sv ====
// Single port register file
`timescale 1ns/1ns
`default_nettype none

module regFile
(
	input wire logic clk,
	input quplsPkg::aregno_t portAddr,
	input wire logic portWe,
	input quplsPkg::value_t portData,
	output quplsPkg::value_t rdData
);

	import quplsPkg::*;

	// ======================================================================
	// Storage
	// ======================================================================

	// r0 is never written because the writer drops it and the fetcher
	// never reads it
	value_t regs [NUM_REGS];

	// One access per cycle, either a write or a read
	always_ff @(posedge clk)
	begin
		if (portWe)
			regs[portAddr] <= portData;
	end

	// Registered read, data valid the cycle after the address
	// On a write cycle this returns the old contents, which nobody uses
	always_ff @(posedge clk)
	begin
		rdData <= regs[portAddr];
	end

endmodule

`default_nettype wire

// ==== decodeTop.sv ====
// Decode and operand fetch top level
`timescale 1ns/1ns
`default_nettype none

module decodeTop
(
	input wire logic clk,
	input wire logic rst,
	input wire logic instrValid,
	input quplsPkg::instruction_t instr,
	input quplsPkg::regx_t regx,
	output logic busy,
	output logic opValid,
	output quplsPkg::value_t opA,
	output quplsPkg::value_t opB,
	output quplsPkg::value_t opC,
	output quplsPkg::aregno_t opRt,
	output quplsPkg::aregno_t opRc,
	input wire logic wbValid,
	input quplsPkg::aregno_t wbReg,
	input quplsPkg::value_t wbData,
	output logic wbFull
);

	import quplsPkg::*;

	// Decoder to fetcher
	logic decValid;
	aregno_t decRa;
	aregno_t decRb;
	aregno_t decRc;
	aregno_t decRt;

	// Requesters to arbiter
	logic fetchReq;
	logic fetchGnt;
	aregno_t fetchAddr;
	logic wbReq;
	logic wbGnt;
	aregno_t wrAddr;
	value_t wrData;

	// Arbiter to register file
	aregno_t portAddr;
	logic portWe;
	value_t portData;
	value_t rdData;

	// The opcode is for later stages, not needed by the operand fetch
	instrDecoder u_instrDecoder
	(
		.clk(clk),
		.rst(rst),
		.instrValid(instrValid),
		.instr(instr),
		.regx(regx),
		.decValid(decValid),
		.decOp(),
		.decRa(decRa),
		.decRb(decRb),
		.decRc(decRc),
		.decRt(decRt)
	);

	operandFetch u_operandFetch
	(
		.clk(clk),
		.rst(rst),
		.decValid(decValid),
		.decRa(decRa),
		.decRb(decRb),
		.decRc(decRc),
		.decRt(decRt),
		.fetchReq(fetchReq),
		.fetchGnt(fetchGnt),
		.fetchAddr(fetchAddr),
		.rdData(rdData),
		.busy(busy),
		.opValid(opValid),
		.opA(opA),
		.opB(opB),
		.opC(opC),
		.opRt(opRt),
		.opRc(opRc)
	);

	regWriter u_regWriter
	(
		.clk(clk),
		.rst(rst),
		.wbValid(wbValid),
		.wbReg(wbReg),
		.wbData(wbData),
		.wbFull(wbFull),
		.wbReq(wbReq),
		.wbGnt(wbGnt),
		.wrAddr(wrAddr),
		.wrData(wrData)
	);

	regArbiter u_regArbiter
	(
		.wbReq(wbReq),
		.fetchReq(fetchReq),
		.wbGnt(wbGnt),
		.fetchGnt(fetchGnt),
		.wrAddr(wrAddr),
		.wrData(wrData),
		.fetchAddr(fetchAddr),
		.portAddr(portAddr),
		.portWe(portWe),
		.portData(portData)
	);

	regFile u_regFile
	(
		.clk(clk),
		.portAddr(portAddr),
		.portWe(portWe),
		.portData(portData),
		.rdData(rdData)
	);

endmodule

`default_nettype wire

// ==== tb_decodeTop.sv ====
// Decode front end testbench
`timescale 1ns/1ns
`default_nettype none

module tb_decodeTop;

	import quplsPkg::*;

	// Tests after the preload, and the cycle budget that each one gets
	localparam int NUM_TESTS = 6;
	localparam int TEST_CYCLES = 200;
	// The preload writes every register at about three cycles apiece
	localparam int PRELOAD_CYCLES = NUM_REGS * 4;
	// No single instruction should take this long to reach opValid
	localparam int OP_TIMEOUT = 100;

	logic clk;
	logic rst;
	logic instrValid;
	instruction_t instr;
	regx_t regx;
	logic busy;
	logic opValid;
	value_t opA;
	value_t opB;
	value_t opC;
	aregno_t opRt;
	aregno_t opRc;
	logic wbValid;
	aregno_t wbReg;
	value_t wbData;
	logic wbFull;

	// Expected contents of the register file
	value_t model [NUM_REGS];
	integer seed;
	string testName;
	// Cycles from the end of the last instruction pulse to its opValid
	int lastLatency;

	decodeTop u_decodeTop
	(
		.clk(clk),
		.rst(rst),
		.instrValid(instrValid),
		.instr(instr),
		.regx(regx),
		.busy(busy),
		.opValid(opValid),
		.opA(opA),
		.opB(opB),
		.opC(opC),
		.opRt(opRt),
		.opRc(opRc),
		.wbValid(wbValid),
		.wbReg(wbReg),
		.wbData(wbData),
		.wbFull(wbFull)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// The whole run must fit in the summed budget of the preload and the tests
	initial
	begin
		repeat (NUM_TESTS * TEST_CYCLES + PRELOAD_CYCLES) @(posedge clk);
		$display("Watchdog expired before the tests finished");
		$display("*** FAILED ***");
		$fatal(1, "simulation timed out");
	end

	// ======================================================================
	// Reference model of the field rules
	// ======================================================================

	// Rc sits highest and Rt lowest, just above the opcode
	function automatic instruction_t makeInstr(opcode_e op, logic [5:0] rt6,
		logic [5:0] ra6, logic [5:0] rb6, logic [5:0] rc6);
		return {1'b0, rc6, rb6, ra6, rt6, op};
	endfunction

	// Stores have no target, everything else takes prefix bit 0 on Rt
	function automatic aregno_t expectRt(instruction_t word, regx_t prefix);
		case (word[6:0])
		OP_STB, OP_STW, OP_STT, OP_STO, OP_STX: return 7'd0;
		default: return {prefix[0], word[12:7]};
		endcase
	endfunction

	// Return picks 56 plus a two-bit field, stores reuse the Rt slot
	function automatic aregno_t expectRc(instruction_t word, regx_t prefix);
		case (word[6:0])
		OP_RTD: return 7'd56 + {5'd0, word[8:7]};
		OP_STB, OP_STW, OP_STT, OP_STO, OP_STX: return {prefix[0], word[12:7]};
		default: return {prefix[3], word[30:25]};
		endcase
	endfunction

	// r0 always reads as zero
	function automatic value_t regValue(aregno_t r);
		return (r == 7'd0) ? 64'd0 : model[r];
	endfunction

	// ======================================================================
	// Drivers and checks
	// ======================================================================

	task automatic check(input string what, input logic [63:0] expected,
		input logic [63:0] actual);
		if (expected !== actual)
		begin
			$display("ERR %s %s expected %h actual %h", testName, what, expected, actual);
			$display("*** FAILED ***");
			$fatal(1, "stopping at the first mismatch");
		end
	endtask

	// Called at a falling edge, returns at a falling edge
	task automatic writeReg(input aregno_t r, input value_t v);
		while (wbFull)
			@(negedge clk);
		@(posedge clk);
		wbValid <= 1'b1;
		wbReg <= r;
		wbData <= v;
		@(posedge clk);
		wbValid <= 1'b0;
		@(negedge clk);
		// The writer drops r0, so the model does too
		if (r != 7'd0)
			model[r] = v;
	endtask

	task automatic issueInstr(input instruction_t word, input regx_t prefix);
		@(posedge clk);
		instrValid <= 1'b1;
		instr <= word;
		regx <= prefix;
		@(posedge clk);
		instrValid <= 1'b0;
	endtask

	task automatic waitOpValid(output int cycles);
		cycles = 0;
		@(negedge clk);
		while (!opValid)
		begin
			cycles++;
			if (cycles > OP_TIMEOUT)
			begin
				$display("No opValid within %0d cycles of the instruction", OP_TIMEOUT);
				$display("*** FAILED ***");
				$fatal(1, "operand fetch hung");
			end
			@(negedge clk);
			// From the cycle after decValid the fetcher stays busy until opValid
			if (!opValid)
				check("busy", 64'd1, 64'(busy));
		end
	endtask

	// Issues one instruction and compares every operand output with the model
	task automatic runInstr(input instruction_t word, input regx_t prefix);
		aregno_t ra;
		aregno_t rb;
		ra = {prefix[1], word[18:13]};
		rb = {prefix[2], word[24:19]};
		issueInstr(word, prefix);
		waitOpValid(lastLatency);
		check("opA", regValue(ra), opA);
		check("opB", regValue(rb), opB);
		check("opC", regValue(expectRc(word, prefix)), opC);
		check("opRt", 64'(expectRt(word, prefix)), 64'(opRt));
		check("opRc", 64'(expectRc(word, prefix)), 64'(opRc));
		// Once the operands are out the fetcher is idle again
		@(negedge clk);
		check("busy after opValid", 64'd0, 64'(busy));
	endtask

	// ======================================================================
	// Tests
	// ======================================================================

	// Every register gets a known value before anything reads it
	task automatic preload();
		testName = "preload";
		for (int r = 1; r < NUM_REGS; r++)
			writeReg(7'(r), {$random(seed), $random(seed)});
	endtask

	task automatic randomAdd();
		logic [5:0] ra6;
		logic [5:0] rb6;
		regx_t prefix;
		testName = "randomAdd";
		for (int i = 0; i < 8; i++)
		begin
			ra6 = 6'($random(seed));
			rb6 = 6'($random(seed));
			prefix = 4'($random(seed));
			writeReg({prefix[1], ra6}, {$random(seed), $random(seed)});
			writeReg({prefix[2], rb6}, {$random(seed), $random(seed)});
			runInstr(makeInstr(OP_ADD, 6'($random(seed)), ra6, rb6, 6'($random(seed))),
				prefix);
		end
	endtask

	task automatic storeRc();
		opcode_e stores [5];
		regx_t prefix;
		instruction_t word;
		stores = '{OP_STB, OP_STW, OP_STT, OP_STO, OP_STX};
		testName = "storeRc";
		foreach (stores[i])
		begin
			prefix = 4'($random(seed));
			word = makeInstr(stores[i], 6'($random(seed)), 6'($random(seed)),
				6'($random(seed)), 6'($random(seed)));
			runInstr(word, prefix);
			check("store Rc", 64'({prefix[0], word[12:7]}), 64'(opRc));
			check("store Rt", 64'd0, 64'(opRt));
		end
	endtask

	task automatic rtdRc();
		testName = "rtdRc";
		for (int f = 0; f < 4; f++)
		begin
			runInstr(makeInstr(OP_RTD, {4'($random(seed)), 2'(f)}, 6'($random(seed)),
				6'($random(seed)), 6'($random(seed))), 4'($random(seed)));
			check("rtd Rc", 64'(56 + f), 64'(opRc));
			check("rtd opC", regValue(7'(56 + f)), opC);
		end
	endtask

	task automatic zeroReg();
		testName = "zeroReg";
		// A write to r0 never occupies the buffer
		writeReg(7'd0, {$random(seed), $random(seed)});
		check("wbFull", 64'd0, 64'(wbFull));
		runInstr(makeInstr(OP_ADD, 6'd0, 6'd0, 6'd0, 6'd0), 4'd0);
		check("r0 read", 64'd0, opA);
	endtask

	task automatic wbContention();
		instruction_t word;
		int base;
		testName = "wbContention";
		word = makeInstr(OP_ADD, 6'd4, 6'd1, 6'd2, 6'd3);
		runInstr(word, 4'd0);
		base = lastLatency;
		fork
			runInstr(word, 4'd0);
			begin
				// Let the previous fetch end and the new one start
				while (busy)
					@(negedge clk);
				while (!busy)
					@(negedge clk);
				// Targets are outside r1 to r3 so the operands stay the same
				for (int i = 0; i < 4; i++)
					writeReg(7'(10 + i), {$random(seed), $random(seed)});
			end
		join
		check("latency grew", 64'd1, 64'(lastLatency > base));
		// The stolen cycles must still have written the file
		runInstr(makeInstr(OP_ADD, 6'd5, 6'd10, 6'd11, 6'd12), 4'd0);
	endtask

	// Ra and Rb show through opA and opB, since r and r+64 hold different values
	task automatic prefixSweep();
		regx_t prefix;
		testName = "prefixSweep";
		for (int p = 0; p < 16; p++)
		begin
			prefix = 4'(p);
			runInstr(makeInstr(OP_ADD, 6'($random(seed)), 6'($random(seed)),
				6'($random(seed)), 6'($random(seed))), prefix);
			check("Rt prefix", 64'(prefix[0]), 64'(opRt >= 7'd64));
			check("Rc prefix", 64'(prefix[3]), 64'(opRc >= 7'd64));
		end
	endtask

	initial
	begin
		seed = 85527;
		rst <= 1'b1;
		instrValid <= 1'b0;
		instr <= '0;
		regx <= '0;
		wbValid <= 1'b0;
		wbReg <= '0;
		wbData <= '0;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		preload();
		randomAdd();
		storeRc();
		rtdRc();
		zeroReg();
		wbContention();
		prefixSweep();
		$display("*** PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
quplsPkg.sv
decodeRc.sv
instrDecoder.sv
operandFetch.sv
regWriter.sv
regArbiter.sv
regFile.sv
decodeTop.sv
tb_decodeTop.sv

// ==== run.sh ====
#!/bin/sh
# Build the decode front end with its testbench and run it under Verilator
verilator --binary --timing --assert --top-module tb_decodeTop -f src.f -o simv \
	&& ./obj_dir/simv | tee /dev/stderr | grep -F -e '*** PASSED ***' > /dev/null \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
